// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = llm_tb
FILELIST = compile.f
OBJ_DIR  = obj_dir
LOG      = sim.log

SOURCES  = $(shell cat $(FILELIST))
BIN      = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: compile.f
logic/llm_pkg.sv
logic/llm_free_list.sv
logic/llm_link_ram.sv
logic/llm_chain_builder.sv
logic/llm_chain_walker.sv
logic/llm_walker_regs.sv
logic/llm_top.sv
sim/llm_tb.sv

// File: logic/llm_chain_builder.sv
`timescale 1ns/100ps

module llm_chain_builder
  (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          pkt_srdy,
  output logic                          pkt_drdy,
  input  logic [llm_pkg::len_bits-1:0]  pkt_pages,
  input  logic                          alloc_srdy,
  output logic                          alloc_drdy,
  input  logic [llm_pkg::page_bits-1:0] alloc_page,
  output logic                          wr_en,
  output logic [llm_pkg::page_bits-1:0] wr_addr,
  output llm_pkg::link_t                wr_link,
  output logic                          head_srdy,
  input  logic                          head_drdy,
  output logic [llm_pkg::page_bits-1:0] head_page
  );
  import llm_pkg::*;

  typedef enum logic [1:0] {
    bld_idle,
    bld_alloc,
    bld_stop,
    bld_hand
  } build_state_t;

  build_state_t         state;
  build_state_t         next_state;
  logic [len_bits-1:0]  remain;
  logic [page_bits-1:0] prev_page;
  logic                 have_prev;
  logic                 take;

  assign take       = alloc_srdy && alloc_drdy;
  assign alloc_drdy = (state == bld_alloc);
  assign head_srdy  = (state == bld_hand);

  // link of the previous page points at the new one, stop entry at the end
  assign wr_en   = (take && have_prev) || (state == bld_stop);
  assign wr_addr = prev_page;
  assign wr_link = (state == bld_stop) ? link_t'{stop: 1'b1, page: '0}
                                       : link_t'{stop: 1'b0, page: alloc_page};

  always_comb
  begin
    next_state = state;
    case (state)
      bld_idle:  if (pkt_srdy && pkt_drdy) next_state = bld_alloc;
      bld_alloc: if (take && (remain == len_bits'(1))) next_state = bld_stop;
      bld_stop:  next_state = bld_hand;
      bld_hand:  if (head_drdy) next_state = bld_idle;
      default:   next_state = bld_idle;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state    <= bld_idle;
      pkt_drdy <= 1'b0;
    end
    else
    begin
      state    <= next_state;
      pkt_drdy <= (next_state == bld_idle);
    end
  end

  always_ff @(posedge clk)
  begin
    if (pkt_srdy && pkt_drdy)
    begin
      remain    <= pkt_pages;
      have_prev <= 1'b0;
    end
    else if (take)
    begin
      remain    <= remain - 1'b1;
      prev_page <= alloc_page;
      have_prev <= 1'b1;
      if (!have_prev)
        head_page <= alloc_page;   // first page is the chain head
    end
  end

  a_pkt_len_legal: assert property (@(posedge clk) disable iff (reset)
    (pkt_srdy && pkt_drdy) |-> (pkt_pages != '0) && (pkt_pages <= max_pkt_pages));

endmodule

// File: logic/llm_chain_walker.sv
`timescale 1ns/100ps

module llm_chain_walker
  (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          head_srdy,
  output logic                          head_drdy,
  input  logic [llm_pkg::page_bits-1:0] head_page,
  output logic                          rd_en,
  output logic [llm_pkg::page_bits-1:0] rd_addr,
  input  llm_pkg::link_t                rd_link,
  output logic                          free_srdy,
  input  logic                          free_drdy,
  output logic [llm_pkg::page_bits-1:0] free_page,
  input  logic                          walk_enable,
  output logic                          done_srdy,
  input  logic                          done_drdy,
  output logic [llm_pkg::page_bits-1:0] done_head,
  output logic [llm_pkg::len_bits-1:0]  done_pages,
  output logic                          pkt_done,
  output logic                          page_freed
  );
  import llm_pkg::*;

  localparam int hq_ptr_bits = $clog2(head_q_depth);

  logic [page_bits-1:0]   hq_mem [head_q_depth];
  logic [hq_ptr_bits-1:0] hq_wr;
  logic [hq_ptr_bits-1:0] hq_rd;
  logic [hq_ptr_bits:0]   hq_cnt;
  logic                   hq_push;
  logic                   hq_pop;
  walk_state_t            state;
  logic [page_bits-1:0]   cur_page;
  logic [page_bits-1:0]   pkt_head;
  logic [len_bits-1:0]    pages;
  link_t                  link_q;

  assign head_drdy = (hq_cnt != head_q_depth);
  assign hq_push   = head_srdy && head_drdy;
  assign hq_pop    = (state == pop);

  assign rd_en      = (state == read);
  assign rd_addr    = cur_page;
  assign free_srdy  = (state == free);
  assign free_page  = cur_page;
  assign done_srdy  = (state == report);
  assign done_head  = pkt_head;
  assign done_pages = pages;
  assign pkt_done   = done_srdy && done_drdy;
  assign page_freed = free_srdy && free_drdy;

  always_ff @(posedge clk)
  begin
    if (hq_push)
      hq_mem[hq_wr] <= head_page;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      hq_wr  <= '0;
      hq_rd  <= '0;
      hq_cnt <= '0;
      state  <= idle;
    end
    else
    begin
      if (hq_push)
        hq_wr <= hq_wr + 1'b1;
      if (hq_pop)
        hq_rd <= hq_rd + 1'b1;
      hq_cnt <= hq_cnt + hq_push - hq_pop;
      case (state)
        idle:      if (walk_enable && (hq_cnt != '0)) state <= pop;  // only between chains
        pop:       state <= read;
        read:      state <= wait_link;
        wait_link: state <= free;
        free:      if (free_drdy) state <= link_q.stop ? report : read;
        report:    if (done_drdy) state <= idle;
        default:   state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    case (state)
      pop:
      begin
        cur_page <= hq_mem[hq_rd];
        pkt_head <= hq_mem[hq_rd];
        pages    <= '0;
      end
      wait_link: link_q <= rd_link;
      free:
      begin
        if (free_drdy)
        begin
          pages    <= pages + 1'b1;
          cur_page <= link_q.page;   // follow the chain
        end
      end
      default: ;
    endcase
  end

  // a chain longer than any legal request means a broken link
  a_pages_bounded: assert property (@(posedge clk) disable iff (reset)
    (state == report) |-> (pages != '0) && (pages <= max_pkt_pages));

endmodule

// File: logic/llm_free_list.sv
`timescale 1ns/100ps

module llm_free_list
  (
  input  logic                          clk,
  input  logic                          reset,
  output logic                          alloc_srdy,
  input  logic                          alloc_drdy,
  output logic [llm_pkg::page_bits-1:0] alloc_page,
  input  logic                          free_srdy,
  output logic                          free_drdy,
  input  logic [llm_pkg::page_bits-1:0] free_page,
  output logic [llm_pkg::page_bits:0]   free_count,
  output logic                          init_done
  );
  import llm_pkg::*;

  logic [page_bits-1:0] fl_mem [num_pages];
  logic [page_bits-1:0] rd_ptr;
  logic [page_bits-1:0] wr_ptr;
  logic [page_bits:0]   count;
  logic [page_bits-1:0] init_page;
  logic                 push;
  logic                 pop;
  logic [page_bits-1:0] push_page;

  assign alloc_srdy = init_done && (count != '0);
  assign alloc_page = fl_mem[rd_ptr];
  assign free_drdy  = init_done;   // frees are never stalled
  assign free_count = count;

  assign pop       = alloc_srdy && alloc_drdy;
  assign push      = !init_done || (free_srdy && free_drdy);
  assign push_page = init_done ? free_page : init_page;

  always_ff @(posedge clk)
  begin
    if (push)
      fl_mem[wr_ptr] <= push_page;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rd_ptr    <= '0;
      wr_ptr    <= '0;
      count     <= '0;
      init_page <= '0;
      init_done <= 1'b0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;   // wraps at num_pages
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // fill pages 0..num_pages-1 in order
      if (!init_done)
      begin
        init_page <= init_page + 1'b1;
        if (init_page == page_bits'(num_pages - 1))
          init_done <= 1'b1;
      end
    end
  end

  // emptiness judged from the pointers instead of the count
  a_no_empty_alloc: assert property (@(posedge clk) disable iff (reset)
    pop |-> (wr_ptr != rd_ptr) || (count == num_pages));

  // a walker freeing more pages than were handed out
  a_no_free_when_full: assert property (@(posedge clk) disable iff (reset)
    (init_done && free_srdy && !pop) |-> (count < num_pages));

endmodule

// File: logic/llm_link_ram.sv
`timescale 1ns/100ps

module llm_link_ram
  (
  input  logic                          clk,
  input  logic                          wr_en,
  input  logic [llm_pkg::page_bits-1:0] wr_addr,
  input  llm_pkg::link_t                wr_link,
  input  logic                          rd_en,
  input  logic [llm_pkg::page_bits-1:0] rd_addr,
  output llm_pkg::link_t                rd_link
  );
  import llm_pkg::*;

  link_t link_mem [num_pages];

  always_ff @(posedge clk)
  begin
    if (wr_en)
      link_mem[wr_addr] <= wr_link;
  end

  // registered read, entry valid the cycle after rd_en
  always_ff @(posedge clk)
  begin
    if (rd_en)
      rd_link <= link_mem[rd_addr];
  end

endmodule

// File: logic/llm_pkg.sv
package llm_pkg;

  localparam int page_bits     = 6;
  localparam int num_pages     = 64;
  localparam int max_pkt_pages = 16;
  localparam int len_bits      = 5;
  localparam int head_q_depth  = 8;

  // one link memory entry, stop marks the last page of a chain
  typedef struct packed {
    logic                 stop;
    logic [page_bits-1:0] page;
  } link_t;

  typedef enum logic [2:0] {
    idle,
    pop,
    read,
    wait_link,
    free,
    report
  } walk_state_t;

  typedef enum logic [1:0] {
    reg_ctrl       = 2'd0,
    reg_pkt_count  = 2'd1,
    reg_page_count = 2'd2
  } reg_addr_t;

endpackage

// File: logic/llm_top.sv
`timescale 1ns/100ps

module llm_top
  (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          pkt_srdy,
  output logic                          pkt_drdy,
  input  logic [llm_pkg::len_bits-1:0]  pkt_pages,
  output logic                          done_srdy,
  input  logic                          done_drdy,
  output logic [llm_pkg::page_bits-1:0] done_head,
  output logic [llm_pkg::len_bits-1:0]  done_pages,
  output logic [llm_pkg::page_bits:0]   free_count,
  output logic                          init_done,
  input  logic                          cfg_wr,
  input  llm_pkg::reg_addr_t            cfg_addr,
  input  logic [15:0]                   cfg_wdata,
  output logic [15:0]                   cfg_rdata
  );
  import llm_pkg::*;

  logic                 alloc_srdy;
  logic                 alloc_drdy;
  logic [page_bits-1:0] alloc_page;
  logic                 free_srdy;
  logic                 free_drdy;
  logic [page_bits-1:0] free_page;
  logic                 wr_en;
  logic [page_bits-1:0] wr_addr;
  link_t                wr_link;
  logic                 rd_en;
  logic [page_bits-1:0] rd_addr;
  link_t                rd_link;
  logic                 head_srdy;
  logic                 head_drdy;
  logic [page_bits-1:0] head_page;
  logic                 walk_enable;
  logic                 pkt_done;
  logic                 page_freed;

  llm_free_list i_free_list (.*);

  llm_link_ram i_link_ram (.*);

  llm_chain_builder i_chain_builder (.*);

  llm_chain_walker i_chain_walker (.*);

  llm_walker_regs i_walker_regs (.*);

endmodule

// File: logic/llm_walker_regs.sv
`timescale 1ns/100ps

module llm_walker_regs
  (
  input  logic               clk,
  input  logic               reset,
  input  logic               cfg_wr,
  input  llm_pkg::reg_addr_t cfg_addr,
  input  logic [15:0]        cfg_wdata,
  output logic [15:0]        cfg_rdata,
  output logic               walk_enable,
  input  logic               pkt_done,
  input  logic               page_freed
  );
  import llm_pkg::*;

  logic [15:0] pkt_cnt;
  logic [15:0] page_cnt;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      walk_enable <= 1'b1;
      pkt_cnt     <= '0;
      page_cnt    <= '0;
    end
    else
    begin
      if (cfg_wr && (cfg_addr == reg_ctrl))
        walk_enable <= cfg_wdata[0];
      // any write clears, otherwise count and wrap
      if (cfg_wr && (cfg_addr == reg_pkt_count))
        pkt_cnt <= '0;
      else if (pkt_done)
        pkt_cnt <= pkt_cnt + 1'b1;
      if (cfg_wr && (cfg_addr == reg_page_count))
        page_cnt <= '0;
      else if (page_freed)
        page_cnt <= page_cnt + 1'b1;
    end
  end

  always_comb
  begin
    case (cfg_addr)
      reg_ctrl:       cfg_rdata = {15'd0, walk_enable};
      reg_pkt_count:  cfg_rdata = pkt_cnt;
      reg_page_count: cfg_rdata = page_cnt;
      default:        cfg_rdata = '0;
    endcase
  end

endmodule

// File: sim/llm_tb.sv
`timescale 1ns/100ps

module llm_tb;
  import llm_pkg::*;

  logic                 clk;
  logic                 reset;
  logic                 pkt_srdy;
  logic                 pkt_drdy;
  logic [len_bits-1:0]  pkt_pages;
  logic                 done_srdy;
  logic                 done_drdy = 1'b0;
  logic [page_bits-1:0] done_head;
  logic [len_bits-1:0]  done_pages;
  logic [page_bits:0]   free_count;
  logic                 init_done;
  logic                 cfg_wr;
  reg_addr_t            cfg_addr;
  logic [15:0]          cfg_wdata;
  logic [15:0]          cfg_rdata;

  logic [35:0]          cmds [64];   // kind, then four byte fields
  logic [page_bits-1:0] free_model [$];
  int                   pend [$];    // page counts of packets not yet reported
  logic                 en_model = 1'b1;
  int                   low_left = 0;
  int                   ncmd;
  int                   total_pages;
  int                   limit = 2000;
  int                   cycles = 0;
  int                   err_done = 0;
  int                   err_reg = 0;
  int                   err_level = 0;
  int                   err_other = 0;

  llm_top i_llm_top (.*);

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic finish_run();
    $display("errors: done %0d, register %0d, level %0d, other %0d",
             err_done, err_reg, err_level, err_other);
    if (err_done + err_reg + err_level + err_other == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  endtask

  task automatic check_done(input logic [page_bits-1:0] exp_head,
                            input logic [len_bits-1:0] exp_pages);
    if (done_head !== exp_head)
    begin
      err_done++;
      $display("FAILED done_head: got %h, expected %h", done_head, exp_head);
    end
    if (done_pages !== exp_pages)
    begin
      err_done++;
      $display("FAILED done_pages: got %h, expected %h", done_pages, exp_pages);
    end
  endtask

  task automatic check_reg(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp)
    begin
      err_reg++;
      $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_free(input logic [page_bits:0] exp);
    if (free_count !== exp)
    begin
      err_reg++;
      $display("FAILED free_count: got %h, expected %h", free_count, exp);
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      err_level++;
      $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // pages leave the model front in packet order and rejoin at the back
  task automatic take_report();
    int                   n;
    logic [page_bits-1:0] chain [$];
    if (pend.size() == 0)
    begin
      err_other++;
      $display("a report arrived with no packet outstanding");
      return;
    end
    n = pend.pop_front();
    for (int i = 0; i < n; i++)
      chain.push_back(free_model.pop_front());
    check_done(chain[0], len_bits'(n));
    foreach (chain[i])
      free_model.push_back(chain[i]);
  endtask

  initial
  begin
    void'($urandom(32'h39b3_54f0));
    forever
    begin
      @(negedge clk);
      if (low_left != 0)
      begin
        done_drdy = 1'b0;
        low_left  = low_left - 1;
      end
      else if ($urandom % 8 == 0)
      begin
        done_drdy = 1'b0;
        low_left  = $urandom % 24;   // long enough to back up the head queue
      end
      else
        done_drdy = 1'b1;
      if (done_srdy && !en_model)
      begin
        err_other++;
        $display("a report came out while the walker was disabled");
      end
      if (done_srdy && done_drdy)
        take_report();
    end
  end

  task automatic send_packet(input logic [len_bits-1:0] n);
    @(negedge clk);
    pkt_srdy  = 1'b1;
    pkt_pages = n;
    while (!pkt_drdy)
      @(negedge clk);
    @(posedge clk);
    pend.push_back(int'(n));
    @(negedge clk);
    pkt_srdy = 1'b0;
  endtask

  task automatic write_reg(input reg_addr_t addr, input logic [15:0] data);
    @(negedge clk);
    cfg_wr    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(posedge clk);
    if (addr == reg_ctrl)
      en_model = data[0];
    @(negedge clk);
    cfg_wr = 1'b0;
  endtask

  task automatic drain_and_check(input logic [15:0] exp_pkts, input logic [15:0] exp_pages);
    while (pend.size() != 0)
      @(posedge clk);
    @(negedge clk);
    cfg_addr = reg_pkt_count;
    check_free((page_bits+1)'(num_pages));
    @(negedge clk);
    check_reg("pkt_count", cfg_rdata, exp_pkts);
    cfg_addr = reg_page_count;
    @(negedge clk);
    check_reg("page_count", cfg_rdata, exp_pages);
  endtask

  task automatic run_command(input logic [35:0] cmd);
    case (cmd[35:32])
      4'h1:
        for (int b = 3; b >= 0; b--)
          if (cmd[8*b +: 8] != 8'h00)
            send_packet(len_bits'(cmd[8*b +: 8]));
      4'h2: write_reg(reg_addr_t'(cmd[25:24]), cmd[15:0]);
      4'h3: drain_and_check(cmd[31:16], cmd[15:0]);
      4'h4: repeat (cmd[15:0]) @(posedge clk);
      4'h5:
      begin
        @(negedge clk);
        check_level("pkt_drdy", pkt_drdy, cmd[0]);
      end
      default:
      begin
        err_other++;
        $display("unknown command %h in the test data", cmd);
      end
    endcase
  endtask

  initial
  begin
    reset     = 1'b1;
    pkt_srdy  = 1'b0;
    pkt_pages = '0;
    cfg_wr    = 1'b0;
    cfg_addr  = reg_ctrl;
    cfg_wdata = '0;
    for (int p = 0; p < num_pages; p++)
      free_model.push_back(page_bits'(p));
    $readmemh("sim/llm_testdata.txt", cmds);
    ncmd        = 0;
    total_pages = 0;
    while (ncmd < $size(cmds) && cmds[ncmd][35:32] != 4'h0)
    begin
      if (cmds[ncmd][35:32] == 4'h1)
        for (int b = 0; b < 4; b++)
          total_pages += int'(cmds[ncmd][8*b +: 8]);
      ncmd++;
    end
    limit = 64 * total_pages + 2000;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    while (!init_done)
      @(negedge clk);
    check_free((page_bits+1)'(num_pages));   // every page queued once init ends
    for (int c = 0; c < ncmd; c++)
      run_command(cmds[c]);
    finish_run();
  end

  initial
  begin
    @(posedge clk);
    while (cycles < limit)
    begin
      @(posedge clk);
      cycles++;
    end
    err_other++;
    $display("run stopped after %0d cycles without finishing", cycles);
    finish_run();
  end

endmodule

// File: sim/llm_testdata.txt
// kind_f0_f1_f2_f3  1 packets (each nonzero byte is a page count)  2 write (f0 addr, f2f3 data)
// 3 drain, check counters (f0f1 packets, f2f3 pages)  4 wait f2f3 cycles  5 expect pkt_drdy = f3
1_01_00_00_00
3_0001_0001
1_03_05_02_10
1_07_01_04_00
3_0008_0027
2_01_00_0000
3_0000_0027
2_02_00_0000
3_0000_0000
2_00_00_0000
1_01_02_03_04
1_05_06_07_08
1_02_00_00_00
4_00_00_012c
5_00_00_0000
2_00_00_0001
3_0009_0026
1_01_03_02_01
1_01_02_01_03
1_01_10_02_01
1_01_04_01_02
1_01_01_03_01
3_001d_0056
1_10_10_10_10
3_0021_0096
0_00_00_0000
